// ==== sms_host_params.svh ====
`ifndef SMS_HOST_PARAMS_SVH
`define SMS_HOST_PARAMS_SVH

// ==========================================================================
// Clock enables
// ==========================================================================

// One full enable pattern in clk_sys ticks
`define SMS_CE_PERIOD 30

// ==========================================================================
// Download and cartridge memory
// ==========================================================================

`define SMS_DL_ADDR_W 25
// Byte address into the external ROM memory
`define SMS_ROM_ADDR_W 24

// Flags, address, compare and replace words
`define SMS_CHEAT_W 128

// ==========================================================================
// Backup RAM image
// ==========================================================================

// 512-byte SD blocks per backup image
`define SMS_BK_BLOCKS 64
`define SMS_BK_BLOCK_W 6
`define SMS_LBA_W 32

`endif

// ==== sms_host_pkg.sv ====
`default_nettype none

package sms_host_pkg;

	// Download index as sent by the host
	// Every index except DL_CHEAT carries a cartridge image
	typedef enum logic [7:0] {
		DL_CART_SMS = 8'd1,
		DL_CART_GG  = 8'd2,
		DL_CHEAT    = 8'hFF
	} dl_slot_t;

	// Backup transfer with one pass of WAIT_ACK and WAIT_RELEASE per block
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_WAIT_ACK,
		BK_WAIT_RELEASE
	} bk_state_t;

	// 32-bit word of the cheat code selected by offset bits 3:2
	typedef enum logic [1:0] {
		CF_FLAGS,
		CF_ADDR,
		CF_COMPARE,
		CF_REPLACE
	} cheat_field_t;

	// Cartridge slot decode used by the loader
	function automatic logic is_cart_slot(input dl_slot_t idx);
		return idx != DL_CHEAT;
	endfunction

endpackage

`default_nettype wire

// ==== ce_divider.sv ====
`default_nettype none
`include "sms_host_params.svh"

module ce_divider (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix
);

	localparam int phase_w = $clog2(`SMS_CE_PERIOD);
	localparam logic [phase_w-1:0] phase_last = phase_w'(`SMS_CE_PERIOD - 1);

	logic [phase_w-1:0] phase;
	logic               hit_cpu;
	logic               hit_vdp;
	logic               hit_pix;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == phase_last) begin
			phase <= '0;
		end else begin
			phase <= phase + phase_w'(1);
		end
	end

	// VDP every 5, pixel every 10, CPU every 15
	// CPU on 9 and 24 keeps the H counter alignment
	always_comb begin
		hit_cpu = 1'b0;
		hit_vdp = 1'b0;
		hit_pix = 1'b0;
		case (phase)
			phase_w'(4), phase_w'(14): begin
				hit_vdp = 1'b1;
			end
			phase_w'(9): begin
				hit_vdp = 1'b1;
				hit_pix = 1'b1;
				hit_cpu = 1'b1;
			end
			phase_w'(19), phase_w'(29): begin
				hit_vdp = 1'b1;
				hit_pix = 1'b1;
			end
			phase_w'(24): begin
				hit_vdp = 1'b1;
				hit_cpu = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
		end else begin
			ce_cpu <= hit_cpu;
			ce_vdp <= hit_vdp;
			ce_pix <= hit_pix;
		end
	end

	a_cpu_with_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_cpu |-> ce_vdp)
		else $error("ce_cpu without ce_vdp");

endmodule

`default_nettype wire

// ==== cart_loader.sv ====
`default_nettype none
`include "sms_host_params.svh"

module cart_loader
	import sms_host_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       dl_active,
	input  dl_slot_t                   dl_index,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_data,
	input  logic                       rom_wr_ack,
	output logic                       dl_wait,
	output logic                       rom_wr_req,
	output logic [`SMS_ROM_ADDR_W-1:0] rom_wr_addr,
	output logic [7:0]                 rom_wr_data,
	output logic                       cart_gg,
	output logic                       cart_loading
);

	logic loading_q;
	logic load_start;
	logic byte_accept;
	logic mem_done;

	assign cart_loading = dl_active && is_cart_slot(dl_index);
	assign load_start   = cart_loading && !loading_q;
	assign byte_accept  = dl_wr && cart_loading && !load_start;

	// Memory has caught up once both toggles agree
	assign mem_done = dl_wait && (rom_wr_req == rom_wr_ack);

	// ==========================================================================
	// Toggle handshake and address counter
	// ==========================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			loading_q   <= 1'b0;
			dl_wait     <= 1'b0;
			rom_wr_req  <= 1'b0;
			rom_wr_addr <= '0;
			cart_gg     <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			if (load_start) begin
				rom_wr_addr <= '0;
				cart_gg     <= (dl_index == DL_CART_GG);
			end else if (byte_accept) begin
				// Stall the stream until memory confirms
				dl_wait    <= 1'b1;
				rom_wr_req <= ~rom_wr_req;
			end else if (mem_done) begin
				dl_wait     <= 1'b0;
				rom_wr_addr <= rom_wr_addr + `SMS_ROM_ADDR_W'(1);
			end
		end
	end

	// Byte held until the next accepted write
	always_ff @(posedge clk_sys) begin
		if (byte_accept) begin
			rom_wr_data <= dl_data;
		end
	end

	// ==========================================================================
	// Checks
	// ==========================================================================

	// Source must honour dl_wait
	a_no_toggle_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_wait |=> $stable(rom_wr_req))
		else $error("rom_wr_req toggled while dl_wait was high");

	// Memory only answers an outstanding request
	a_ack_while_waiting: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rom_wr_req != rom_wr_ack) |-> dl_wait)
		else $error("rom_wr_ack differs from rom_wr_req outside a write");

endmodule

`default_nettype wire

// ==== cheat_loader.sv ====
`default_nettype none
`include "sms_host_params.svh"

module cheat_loader
	import sms_host_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    dl_active,
	input  dl_slot_t                dl_index,
	input  logic                    dl_wr,
	input  logic [3:0]              dl_addr,
	input  logic [7:0]              dl_data,
	output logic [`SMS_CHEAT_W-1:0] cheat_code,
	output logic                    cheat_valid
);

	localparam int sel_w   = $clog2(`SMS_CHEAT_W);
	localparam int field_w = `SMS_CHEAT_W / 4;

	logic             code_wr;
	cheat_field_t     field;
	logic [sel_w-1:0] field_lsb;
	logic [sel_w-1:0] byte_lsb;

	assign code_wr = dl_active && (dl_index == DL_CHEAT) && dl_wr;
	assign field   = cheat_field_t'(dl_addr[3:2]);

	// Flags in the top word, replace value in the bottom word
	always_comb begin
		field_lsb = '0;
		case (field)
			CF_FLAGS:   field_lsb = sel_w'(3 * field_w);
			CF_ADDR:    field_lsb = sel_w'(2 * field_w);
			CF_COMPARE: field_lsb = sel_w'(field_w);
			CF_REPLACE: field_lsb = '0;
		endcase
	end

	// Byte 0 is the least significant byte of its word
	assign byte_lsb = field_lsb + sel_w'({dl_addr[1:0], 3'b000});

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code[byte_lsb +: 8] <= dl_data;
		end
	end

	// Last byte of the code completes it
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl_addr == 4'hF);
		end
	end

endmodule

`default_nettype wire

// ==== backup_sequencer.sv ====
`default_nettype none
`include "sms_host_params.svh"

module backup_sequencer
	import sms_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  cart_loading,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  img_size_nz,
	input  logic                  bk_load_req,
	input  logic                  bk_save_req,
	input  logic                  nvram_we,
	input  logic                  sd_ack,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic [`SMS_LBA_W-1:0] sd_lba,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  bk_pending
);

	localparam logic [`SMS_BK_BLOCK_W-1:0] last_block =
		`SMS_BK_BLOCK_W'(`SMS_BK_BLOCKS - 1);

	bk_state_t bk_state;
	logic      loading_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      bk_ena;
	logic      ack_rise;
	logic      ack_fall;
	logic      auto_start;
	logic      load_start;
	logic      save_start;
	logic      start_rd;
	logic      xfer_start;
	logic      last_blk;

	assign ack_rise   = sd_ack && !ack_q;
	assign ack_fall   = !sd_ack && ack_q;
	assign auto_start = loading_q && !cart_loading && img_size_nz;
	assign load_start = bk_load_req && !load_q;
	assign save_start = bk_save_req && !save_q;
	assign start_rd   = auto_start || load_start;
	assign xfer_start = (bk_state == BK_IDLE) && bk_ena && (start_rd || save_start);
	assign last_blk   = (sd_lba[`SMS_BK_BLOCK_W-1:0] == last_block);
	assign bk_busy    = (bk_state != BK_IDLE);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			loading_q <= 1'b0;
			load_q    <= 1'b0;
			save_q    <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			load_q    <= bk_load_req;
			save_q    <= bk_save_req;
			ack_q     <= sd_ack;
		end
	end

	// ==========================================================================
	// Backup enable and pending flag
	// ==========================================================================

	// Save image is mounted before the download ends
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bk_ena <= 1'b0;
		end else if (cart_loading && img_mounted && !img_readonly) begin
			bk_ena <= 1'b1;
		end else if (cart_loading && !loading_q) begin
			bk_ena <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bk_pending <= 1'b0;
		end else if (xfer_start) begin
			bk_pending <= 1'b0;
		end else if (nvram_we && bk_ena) begin
			bk_pending <= 1'b1;
		end
	end

	// ==========================================================================
	// Block transfer FSM
	// ==========================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bk_state   <= BK_IDLE;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
		end else begin
			case (bk_state)
				BK_IDLE: begin
					if (xfer_start) begin
						bk_state   <= BK_WAIT_ACK;
						sd_lba     <= '0;
						bk_loading <= start_rd;
						sd_rd      <= start_rd;
						sd_wr      <= !start_rd;
					end
				end
				BK_WAIT_ACK: begin
					if (ack_rise) begin
						sd_rd    <= 1'b0;
						sd_wr    <= 1'b0;
						bk_state <= BK_WAIT_RELEASE;
					end
				end
				BK_WAIT_RELEASE: begin
					// Card has released the block
					if (ack_fall) begin
						if (last_blk) begin
							bk_state   <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							bk_state <= BK_WAIT_ACK;
							sd_lba   <= sd_lba + `SMS_LBA_W'(1);
							sd_rd    <= bk_loading;
							sd_wr    <= !bk_loading;
						end
					end
				end
				default: begin
					bk_state <= BK_IDLE;
				end
			endcase
		end
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

endmodule

`default_nettype wire

// ==== sms_host_top.sv ====
`default_nettype none
`include "sms_host_params.svh"

module sms_host_top
	import sms_host_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	output logic                       ce_cpu,
	output logic                       ce_vdp,
	output logic                       ce_pix,
	input  logic                       dl_active,
	input  dl_slot_t                   dl_index,
	input  logic                       dl_wr,
	input  logic [`SMS_DL_ADDR_W-1:0]  dl_addr,
	input  logic [7:0]                 dl_data,
	output logic                       dl_wait,
	output logic                       rom_wr_req,
	output logic [`SMS_ROM_ADDR_W-1:0] rom_wr_addr,
	output logic [7:0]                 rom_wr_data,
	input  logic                       rom_wr_ack,
	output logic                       cart_gg,
	output logic [`SMS_CHEAT_W-1:0]    cheat_code,
	output logic                       cheat_valid,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_size_nz,
	input  logic                       bk_load_req,
	input  logic                       bk_save_req,
	input  logic                       nvram_we,
	input  logic                       sd_ack,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic [`SMS_LBA_W-1:0]      sd_lba,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_pending,
	output logic                       core_reset_n
);

	logic cart_loading;
	logic cart_loading_q;

	ce_divider ce_divider_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix)
	);

	cart_loader cart_loader_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_data      (dl_data),
		.rom_wr_ack   (rom_wr_ack),
		.dl_wait      (dl_wait),
		.rom_wr_req   (rom_wr_req),
		.rom_wr_addr  (rom_wr_addr),
		.rom_wr_data  (rom_wr_data),
		.cart_gg      (cart_gg),
		.cart_loading (cart_loading)
	);

	// Offset inside the 16-byte code
	cheat_loader cheat_loader_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr[3:0]),
		.dl_data     (dl_data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	backup_sequencer backup_sequencer_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.cart_loading (cart_loading),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.nvram_we     (nvram_we),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending)
	);

	// ==========================================================================
	// Core reset
	// ==========================================================================

	// Covers the cycle between download end and the automatic backup load
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cart_loading_q <= 1'b0;
		end else begin
			cart_loading_q <= cart_loading;
		end
	end

	assign core_reset_n = rst_n && !cart_loading && !cart_loading_q && !bk_loading;

endmodule

`default_nettype wire

// ==== tb_sms_host_models.sv ====
`default_nettype none
`include "sms_host_params.svh"

// ==========================================================================
// External ROM memory that answers each request toggle after a delay
// ==========================================================================

module rom_model
	import sms_host_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       rom_wr_req,
	input  logic [`SMS_ROM_ADDR_W-1:0] rom_wr_addr,
	input  logic [7:0]                 rom_wr_data,
	input  logic [2:0]                 ack_delay,
	output logic                       rom_wr_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`SMS_ROM_ADDR_W-1:0] addr_log[$];
	logic [7:0]                 data_log[$];
	int                         hold;

	task automatic clear_log();
		addr_log.delete();
		data_log.delete();
	endtask

	initial begin
		rom_wr_ack = 1'b0;
	end

	// Byte is stored when the memory finally answers
	always begin
		@(posedge clk_sys);
		if (rst_n && (rom_wr_req != rom_wr_ack)) begin
			hold = ack_delay;
			repeat (hold) @(posedge clk_sys);
			addr_log.push_back(rom_wr_addr);
			data_log.push_back(rom_wr_data);
			#1;
			rom_wr_ack = rom_wr_req;
		end
	end

endmodule

// ==========================================================================
// SD card that raises ack after a delay and drops it once the request is gone
// ==========================================================================

module sd_model
	import sms_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  sd_rd,
	input  logic                  sd_wr,
	input  logic [`SMS_LBA_W-1:0] sd_lba,
	input  logic [2:0]            ack_delay,
	output logic                  sd_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`SMS_LBA_W-1:0] lba_log[$];
	// Read line in bit 1, write line in bit 0
	logic [1:0]            dir_log[$];
	int                    hold;

	task automatic clear_log();
		lba_log.delete();
		dir_log.delete();
	endtask

	initial begin
		sd_ack = 1'b0;
	end

	always begin
		@(posedge clk_sys);
		if (rst_n && (sd_rd || sd_wr)) begin
			lba_log.push_back(sd_lba);
			dir_log.push_back({sd_rd, sd_wr});
			hold = ack_delay;
			repeat (hold) @(posedge clk_sys);
			#1;
			sd_ack = 1'b1;
			while (sd_rd || sd_wr) begin
				@(posedge clk_sys);
			end
			hold = ack_delay;
			repeat (hold) @(posedge clk_sys);
			#1;
			sd_ack = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb_sms_host_top.sv ====
`default_nettype none
`include "sms_host_params.svh"

module tb_sms_host_top
	import sms_host_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Roughly 300 + 600 + 50 + 1500 + 1500 cycles of tests, with margin
	localparam int          cycle_limit = 6000;
	localparam logic [31:0] rng_seed    = 32'h0541_fec0;
	localparam int          cart_bytes  = 40;

	logic                       clk_sys;
	logic                       rst_n;
	logic                       ce_cpu;
	logic                       ce_vdp;
	logic                       ce_pix;
	logic                       dl_active;
	dl_slot_t                   dl_index;
	logic                       dl_wr;
	logic [`SMS_DL_ADDR_W-1:0]  dl_addr;
	logic [7:0]                 dl_data;
	logic                       dl_wait;
	logic                       rom_wr_req;
	logic [`SMS_ROM_ADDR_W-1:0] rom_wr_addr;
	logic [7:0]                 rom_wr_data;
	logic                       rom_wr_ack;
	logic                       cart_gg;
	logic [`SMS_CHEAT_W-1:0]    cheat_code;
	logic                       cheat_valid;
	logic                       img_mounted;
	logic                       img_readonly;
	logic                       img_size_nz;
	logic                       bk_load_req;
	logic                       bk_save_req;
	logic                       nvram_we;
	logic                       sd_ack;
	logic                       sd_rd;
	logic                       sd_wr;
	logic [`SMS_LBA_W-1:0]      sd_lba;
	logic                       bk_busy;
	logic                       bk_loading;
	logic                       bk_pending;
	logic                       core_reset_n;

	logic [2:0]              rom_delay;
	logic [2:0]              sd_delay;
	logic [31:0]             data_state;
	logic [31:0]             delay_state;
	logic [7:0]              dl_bytes [0:63];
	logic [`SMS_CHEAT_W-1:0] cheat_expected;
	logic                    ce_counting;
	string                   test_name;
	int                      test_errors;
	int                      pass_count;
	int                      fail_count;
	int                      cycle_count;
	int                      ce_cycle;
	int                      last_pix;
	int                      vdp_count;
	int                      pix_count;
	int                      cpu_count;
	int                      valid_count;
	int                      reset_leaks;

	sms_host_top sms_host_top_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ce_cpu       (ce_cpu),
		.ce_vdp       (ce_vdp),
		.ce_pix       (ce_pix),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wait      (dl_wait),
		.rom_wr_req   (rom_wr_req),
		.rom_wr_addr  (rom_wr_addr),
		.rom_wr_data  (rom_wr_data),
		.rom_wr_ack   (rom_wr_ack),
		.cart_gg      (cart_gg),
		.cheat_code   (cheat_code),
		.cheat_valid  (cheat_valid),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.nvram_we     (nvram_we),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending),
		.core_reset_n (core_reset_n)
	);

	rom_model rom_model_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rom_wr_req  (rom_wr_req),
		.rom_wr_addr (rom_wr_addr),
		.rom_wr_data (rom_wr_data),
		.ack_delay   (rom_delay),
		.rom_wr_ack  (rom_wr_ack)
	);

	sd_model sd_model_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sd_rd     (sd_rd),
		.sd_wr     (sd_wr),
		.sd_lba    (sd_lba),
		.ack_delay (sd_delay),
		.sd_ack    (sd_ack)
	);

	// ==========================================================================
	// Random numbers and reference functions
	// ==========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] next_byte();
		data_state = xorshift32(data_state);
		return data_state[7:0];
	endfunction

	// kind 0 is VDP, 1 is pixel, 2 is CPU
	function automatic int expected_enables(input int kind, input int cycles);
		int n;
		int i;
		int c;
		n = 0;
		for (i = 0; i < cycles; i++) begin
			c = i % `SMS_CE_PERIOD;
			if (kind == 0 && (c % 5) == 4) n++;
			if (kind == 1 && (c % 10) == 9) n++;
			if (kind == 2 && (c == 9 || c == 24)) n++;
		end
		return n;
	endfunction

	// Flags word on top, replace word at the bottom, byte 0 lowest
	function automatic logic [`SMS_CHEAT_W-1:0] assemble_cheat();
		logic [`SMS_CHEAT_W-1:0] code;
		int ofs;
		int lsb;
		code = '0;
		for (ofs = 0; ofs < 16; ofs++) begin
			lsb = (3 - ofs / 4) * 32 + (ofs % 4) * 8;
			code[lsb +: 8] = dl_bytes[ofs];
		end
		return code;
	endfunction

	// ==========================================================================
	// Reporting helpers
	// ==========================================================================

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic expect_equal(input string what, input logic [127:0] exp,
			input logic [127:0] act);
		if (exp !== act) begin
			$display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		test_errors++;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("PASS %s", test_name);
			pass_count++;
		end else begin
			$display("FAIL %s with %0d errors", test_name, test_errors);
			fail_count++;
		end
	endtask

	// ==========================================================================
	// Stimulus helpers called 1 ns after a rising edge
	// ==========================================================================

	task automatic fill_bytes(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			dl_bytes[i] = next_byte();
		end
	endtask

	task automatic send_byte(input int offset, input logic [7:0] value);
		dl_addr = `SMS_DL_ADDR_W'(offset);
		dl_data = value;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		while (dl_wait) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	// Leaves dl_active high so the caller decides when the download ends
	task automatic download_bytes(input dl_slot_t slot, input int count);
		int n;
		dl_index  = slot;
		dl_active = 1'b1;
		// First cycle only clears the address
		@(posedge clk_sys);
		#1;
		for (n = 0; n < count; n++) begin
			send_byte(n, dl_bytes[n]);
		end
	endtask

	task automatic check_rom_log(input int count);
		int i;
		expect_equal("ROM write count", count, rom_model_inst.addr_log.size());
		for (i = 0; i < count && i < rom_model_inst.addr_log.size(); i++) begin
			expect_equal($sformatf("ROM address of byte %0d", i), i,
				rom_model_inst.addr_log[i]);
			expect_equal($sformatf("ROM data at %0d", i), dl_bytes[i],
				rom_model_inst.data_log[i]);
		end
	endtask

	task automatic check_sd_log(input logic is_write);
		int i;
		expect_equal("SD block count", `SMS_BK_BLOCKS, sd_model_inst.lba_log.size());
		for (i = 0; i < sd_model_inst.lba_log.size(); i++) begin
			expect_equal($sformatf("sd_lba of block %0d", i), i, sd_model_inst.lba_log[i]);
			expect_equal($sformatf("sd_rd and sd_wr of block %0d", i),
				{!is_write, is_write}, sd_model_inst.dir_log[i]);
		end
	endtask

	task automatic wait_backup_done();
		while (bk_busy) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	// ==========================================================================
	// Clock, model delays, compare process, timeout
	// ==========================================================================

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		delay_state = rng_seed ^ 32'h5a5a_5a5a;
		rom_delay   = 3'd0;
		sd_delay    = 3'd0;
		forever begin
			@(posedge clk_sys);
			#1;
			delay_state = xorshift32(delay_state);
			rom_delay   = 3'(delay_state[7:0] % 8'd6);
			sd_delay    = 3'(delay_state[15:8] % 8'd6);
		end
	end

	always @(posedge clk_sys) begin
		if (ce_counting) begin
			ce_cycle++;
			if (ce_vdp) vdp_count++;
			if (ce_pix) pix_count++;
			if (ce_cpu) cpu_count++;
			if ((ce_cpu || ce_pix) && !ce_vdp) begin
				report_problem($sformatf("CPU or pixel enable without VDP at cycle %0d",
					ce_cycle));
			end
			if (ce_pix) begin
				if (last_pix >= 0 && (ce_cycle - last_pix) != 10) begin
					expect_equal("pixel enable spacing", 10, ce_cycle - last_pix);
				end
				last_pix = ce_cycle;
			end
		end
		if (cheat_valid) begin
			valid_count++;
			expect_equal("cheat_code at cheat_valid", cheat_expected, cheat_code);
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: run stopped after %0d cycles", cycle_limit);
		$display("Verification failed");
		$finish;
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		rst_n          = 1'b0;
		dl_active      = 1'b0;
		dl_index       = DL_CART_SMS;
		dl_wr          = 1'b0;
		dl_addr        = '0;
		dl_data        = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size_nz    = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		nvram_we       = 1'b0;
		data_state     = rng_seed;
		cheat_expected = '0;
		ce_counting    = 1'b0;
		pass_count     = 0;
		fail_count     = 0;
		valid_count    = 0;
		reset_leaks    = 0;
		start_test("reset");
		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		start_test("clock_enables");
		vdp_count   = 0;
		pix_count   = 0;
		cpu_count   = 0;
		ce_cycle    = 0;
		last_pix    = -1;
		// Enables trail the counter by one cycle
		@(posedge clk_sys);
		#1;
		ce_counting = 1'b1;
		repeat (300) @(posedge clk_sys);
		#1;
		ce_counting = 1'b0;
		expect_equal("VDP enables", expected_enables(0, 300), vdp_count);
		expect_equal("pixel enables", expected_enables(1, 300), pix_count);
		expect_equal("CPU enables", expected_enables(2, 300), cpu_count);
		finish_test();

		start_test("cart_download");
		rom_model_inst.clear_log();
		fill_bytes(cart_bytes);
		download_bytes(DL_CART_GG, cart_bytes);
		dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
		check_rom_log(cart_bytes);
		expect_equal("cart_gg after GG download", 1, cart_gg);
		// SMS image restarts at address 0
		rom_model_inst.clear_log();
		fill_bytes(8);
		download_bytes(DL_CART_SMS, 8);
		dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
		check_rom_log(8);
		expect_equal("cart_gg after SMS download", 0, cart_gg);
		finish_test();

		start_test("cheat_code");
		fill_bytes(16);
		cheat_expected = assemble_cheat();
		valid_count    = 0;
		download_bytes(DL_CHEAT, 16);
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		expect_equal("cheat_valid pulses", 1, valid_count);
		expect_equal("cheat_code", cheat_expected, cheat_code);
		finish_test();

		start_test("backup_save");
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		fill_bytes(4);
		download_bytes(DL_CART_SMS, 4);
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		if (bk_busy) report_problem("transfer started without a request");
		sd_model_inst.clear_log();
		bk_save_req = 1'b1;
		@(posedge clk_sys);
		#1;
		bk_save_req = 1'b0;
		if (!bk_busy) report_problem("save did not start one cycle after the request");
		wait_backup_done();
		check_sd_log(1'b1);
		// One request gives one transfer
		@(posedge clk_sys);
		#1;
		expect_equal("bk_busy after save", 0, bk_busy);
		finish_test();

		start_test("backup_auto_load");
		img_size_nz = 1'b1;
		reset_leaks = 0;
		sd_model_inst.clear_log();
		fill_bytes(4);
		download_bytes(DL_CART_GG, 4);
		dl_active = 1'b0;
		#1;
		if (core_reset_n) report_problem("core_reset_n went high as the download ended");
		@(posedge clk_sys);
		#1;
		if (!bk_loading) report_problem("automatic load did not start");
		while (bk_loading) begin
			if (core_reset_n) reset_leaks++;
			@(posedge clk_sys);
			#1;
		end
		expect_equal("cycles with core_reset_n high while loading", 0, reset_leaks);
		expect_equal("core_reset_n after load", 1, core_reset_n);
		check_sd_log(1'b0);
		expect_equal("bk_busy after load", 0, bk_busy);
		finish_test();

		start_test("backup_pending");
		img_size_nz = 1'b0;
		nvram_we    = 1'b1;
		@(posedge clk_sys);
		#1;
		nvram_we = 1'b0;
		expect_equal("bk_pending after nvram_we", 1, bk_pending);
		bk_load_req = 1'b1;
		@(posedge clk_sys);
		#1;
		bk_load_req = 1'b0;
		if (!bk_busy) report_problem("load did not start after the request");
		expect_equal("bk_pending after transfer start", 0, bk_pending);
		wait_backup_done();
		// Readonly image leaves the backup disabled
		img_readonly = 1'b1;
		fill_bytes(4);
		download_bytes(DL_CART_SMS, 4);
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		nvram_we = 1'b1;
		@(posedge clk_sys);
		#1;
		nvram_we = 1'b0;
		expect_equal("bk_pending with readonly image", 0, bk_pending);
		finish_test();

		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
sms_host_pkg.sv
ce_divider.sv
cart_loader.sv
cheat_loader.sv
backup_sequencer.sv
sms_host_top.sv
tb_sms_host_models.sv
tb_sms_host_top.sv
